//--- bench/board_bus_core_properties.sv
// concurrent checks for board_bus_core, bound into the core
// shadow models of hub memory, watchdog period and broadcast state
// address translation, read data, broadcast and watchdog timing
`timescale 1ns/1ps
`default_nettype none

module board_bus_core_properties #(
    parameter int num_motors    = 4,
    parameter int num_encoders  = 4,
    parameter int wdog_tick     = 8,
    parameter int hub_addr_bits = 6
) (
    input logic        sysclk, rst, blk_rt_rd, reg_wen, wdog_clear,
    input logic        write_trig, wdog_timeout, wdog_period_led,
    input logic [3:0]  board_id,
    input logic [15:0] reg_raddr_in, reg_raddr, reg_waddr, bc_sequence,
    input logic [31:0] reg_wdata, reg_rdata_ext, reg_rdata,
    input logic [2:0]  wdog_period_status
);

    int fail_count = 0;                          // summed up by the bench

    logic [31:0] hub_shadow [2**hub_addr_bits];  // what the host wrote
    logic [2**hub_addr_bits-1:0] hub_written;    // only these locations are checked
    logic [hub_addr_bits-1:0] hub_waddr;
    logic [hub_addr_bits-1:0] hub_raddr;
    logic [15:0] exp_period;
    logic [15:0] exp_seq;
    logic [15:0] bc_mask;
    logic        exp_trig;
    logic        cleared;                        // wdog_clear seen since last host write
    logic        main_wr;
    logic        hub_wr;
    logic [32:0] chan0_exp;                      // claimed flag, then value
    logic [31:0] exp_data_q;
    logic [1:0]  exp_kind_q;                     // 0 skip, 1 exp_data_q, 2 external
    int          idle_cnt;                       // cycles since last main-space write
    int          window_lo;
    int          window_hi;

    // real-time block is channel 0 quadlets, motor pairs, then encoder fields
    function automatic logic [15:0] expected_raddr(logic [15:0] addr_in, logic rt);
        int idx;
        int j;
        int k;
        idx = int'(addr_in[7:0]);
        j   = idx - board_bus_pkg::rt_main_quads;
        k   = j - 2 * num_motors;
        if (!rt)
            return addr_in;
        if (idx < board_bus_pkg::rt_main_quads)
            return {board_bus_pkg::addr_main, 8'h00, 4'(idx)};
        if (j < 2 * num_motors)
            return {board_bus_pkg::addr_main, 4'h0, 4'(j / 2 + 1), 4'(j % 2)};
        if (k < 5 * num_encoders)
            return {board_bus_pkg::addr_main, 4'h0, 4'(k % num_encoders + 1),
                    4'(board_bus_pkg::enc_field_base + k / num_encoders)};
        return 16'h0000;                          // past the block
    endfunction

    function automatic logic [2:0] period_range(logic [15:0] p);
        if (p == 16'd0)
            return 3'd0;
        if (p < 16'd16)
            return 3'd1;
        if (p < 16'd256)
            return 3'd2;
        if (p < 16'd4096)
            return 3'd3;
        return 3'd4;
    endfunction

    function automatic logic [32:0] chan0_model(logic [3:0] offs, logic [3:0] id,
                                                logic tmo, logic [15:0] period);
        case (offs)
            board_bus_pkg::reg_status:  return {1'b1, 4'd0, id, tmo, 23'd0};
            board_bus_pkg::reg_wdog:    return {1'b1, 16'd0, period};
            board_bus_pkg::reg_version: return {1'b1, board_bus_pkg::fw_version};
            board_bus_pkg::reg_ipaddr:  return {1'b1, board_bus_pkg::ip_addr_none};
            board_bus_pkg::reg_ethstat: return {1'b1, 32'd0};
            default:                    return 33'd0;   // answered externally
        endcase
    endfunction

    task automatic flag_mismatch(input string what);
        fail_count++;
        $error("Mismatch at %0t: %s", $time, what);
    endtask

    assign main_wr   = reg_wen && (reg_waddr[15:12] == board_bus_pkg::addr_main);
    assign hub_wr    = reg_wen && (reg_waddr[15:12] == board_bus_pkg::addr_hub);
    assign hub_waddr = reg_waddr[hub_addr_bits-1:0];
    assign hub_raddr = reg_raddr[hub_addr_bits-1:0];
    assign bc_mask   = reg_wdata[31:16];           // one request bit per board
    assign chan0_exp = chan0_model(reg_raddr[3:0], board_id, wdog_timeout, exp_period);
    assign window_lo = int'(exp_period) * wdog_tick;
    assign window_hi = window_lo + wdog_tick + 2;

    // ----------------------------------------
    // shadow state
    // ----------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            hub_written <= '0;
            exp_period  <= 16'd0;
            exp_seq     <= 16'd0;
            exp_trig    <= 1'b0;
            cleared     <= 1'b0;
            idle_cnt    <= 0;
            exp_kind_q  <= 2'd0;
        end else begin
            if (hub_wr) begin
                hub_shadow[hub_waddr]  <= reg_wdata;
                hub_written[hub_waddr] <= 1'b1;
            end
            exp_trig <= hub_wr && (hub_waddr == '0) && bc_mask[board_id];
            if (hub_wr && (hub_waddr == '0))
                exp_seq <= reg_wdata[15:0];
            if (main_wr && (reg_waddr[7:0] == {4'd0, board_bus_pkg::reg_wdog}))
                exp_period <= reg_wdata[15:0];
            idle_cnt <= main_wr ? 0 : idle_cnt + 1;
            cleared  <= main_wr ? 1'b0 : (cleared || wdog_clear);
            // read data expected one cycle later, old hub data on a same-cycle write
            if (reg_raddr[15:12] == board_bus_pkg::addr_hub) begin
                exp_kind_q <= hub_written[hub_raddr] ? 2'd1 : 2'd0;
                exp_data_q <= hub_shadow[hub_raddr];
            end else if ((reg_raddr[15:12] == board_bus_pkg::addr_main) &&
                         (reg_raddr[7:4] == 4'd0) && chan0_exp[32]) begin
                exp_kind_q <= 2'd1;
                exp_data_q <= chan0_exp[31:0];
            end else begin
                exp_kind_q <= 2'd2;                 // external register file
                exp_data_q <= 32'd0;
            end
        end
    end

    // ----------------------------------------
    // assertions
    // ----------------------------------------
    xlate_check: assert property (@(posedge sysclk) disable iff (rst)
        reg_raddr == expected_raddr(reg_raddr_in, blk_rt_rd))
        else flag_mismatch("translated read address");

    read_check: assert property (@(posedge sysclk) disable iff (rst)
        exp_kind_q != 2'd0 |-> reg_rdata == (exp_kind_q == 2'd2 ? reg_rdata_ext : exp_data_q))
        else flag_mismatch("read data");

    broadcast_check: assert property (@(posedge sysclk) disable iff (rst)
        bc_sequence == exp_seq && write_trig == exp_trig)
        else flag_mismatch("broadcast sequence or write trigger");

    period_check: assert property (@(posedge sysclk) disable iff (rst)
        wdog_period_led == (exp_period != 16'd0) &&
        wdog_period_status == period_range(exp_period))
        else flag_mismatch("watchdog period led or range code");

    timeout_drop_check: assert property (@(posedge sysclk) disable iff (rst)
        $past(rst) || $past(wdog_clear) |-> !wdog_timeout)
        else flag_mismatch("watchdog flag after reset or clear");

    timeout_rise_check: assert property (@(posedge sysclk) disable iff (rst)
        $rose(wdog_timeout) |->
            exp_period != 16'd0 && idle_cnt >= window_lo && idle_cnt <= window_hi)
        else flag_mismatch("watchdog flag rose outside its window");

    timeout_late_check: assert property (@(posedge sysclk) disable iff (rst)
        exp_period != 16'd0 && !cleared && idle_cnt >= window_hi |-> wdog_timeout)
        else flag_mismatch("watchdog flag missing after its window");

endmodule

bind board_bus_core board_bus_core_properties #(
    .num_motors (num_motors), .num_encoders (num_encoders),
    .wdog_tick (wdog_tick), .hub_addr_bits (hub_addr_bits)
) i_board_bus_core_properties (
    .sysclk (sysclk), .rst (rst), .blk_rt_rd (blk_rt_rd), .reg_wen (reg_wen),
    .wdog_clear (wdog_clear), .write_trig (write_trig), .wdog_timeout (wdog_timeout),
    .wdog_period_led (wdog_period_led), .board_id (board_id),
    .reg_raddr_in (reg_raddr_in), .reg_raddr (reg_raddr), .reg_waddr (reg_waddr),
    .bc_sequence (bc_sequence), .reg_wdata (reg_wdata), .reg_rdata_ext (reg_rdata_ext),
    .reg_rdata (reg_rdata), .wdog_period_status (wdog_period_status)
);

`default_nettype wire

//--- bench/tb_board_bus_core.sv
// testbench for board_bus_core
// clock, reset, external register model and host bus stimulus
// values are checked by the bound property module
`timescale 1ns/1ps
`default_nettype none

module tb_board_bus_core;

    localparam int         num_motors   = 4;
    localparam int         num_encoders = 4;
    localparam int         wdog_tick    = 8;
    localparam int         block_quads  = 4 + 2 * num_motors + 5 * num_encoders;
    localparam logic [3:0] this_board   = 4'd5;

    logic        sysclk;
    logic        rst;
    logic [15:0] reg_raddr_in;
    logic        blk_rt_rd;
    logic [15:0] reg_waddr;
    logic [31:0] reg_wdata;
    logic        reg_wen;
    logic [15:0] reg_raddr;
    logic [31:0] reg_rdata_ext = 32'd0;
    logic [31:0] reg_rdata;
    logic [15:0] bc_sequence;
    logic        write_trig;
    logic        wdog_clear;
    logic        wdog_timeout;
    logic        wdog_period_led;
    logic [2:0]  wdog_period_status;
    integer      seed;
    int          timeout_count;
    int          fail_total;
    // version, ip, status, wdog, ethstat, unclaimed ch0, channel 2, prom
    logic [15:0] probe_addr [8] = '{16'h0007, 16'h000b, 16'h0000, 16'h0003,
                                    16'h000c, 16'h0005, 16'h0021, 16'h2004};

    board_bus_core #(
        .num_motors (num_motors), .num_encoders (num_encoders),
        .wdog_tick (wdog_tick), .hub_addr_bits (6)
    ) i_board_bus_core (
        .sysclk (sysclk), .rst (rst), .board_id (this_board),
        .reg_raddr_in (reg_raddr_in), .blk_rt_rd (blk_rt_rd), .reg_waddr (reg_waddr),
        .reg_wdata (reg_wdata), .reg_wen (reg_wen), .reg_raddr (reg_raddr),
        .reg_rdata_ext (reg_rdata_ext), .reg_rdata (reg_rdata),
        .bc_sequence (bc_sequence), .write_trig (write_trig), .wdog_clear (wdog_clear),
        .wdog_timeout (wdog_timeout), .wdog_period_led (wdog_period_led),
        .wdog_period_status (wdog_period_status)
    );

    initial begin
        sysclk = 1'b0;
        forever #10 sysclk = ~sysclk;   // 20 ns period
    end

    // external register file, answers one cycle after the address
    always @(posedge sysclk)
        reg_rdata_ext <= {16'he5a5, reg_raddr};

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge sysclk);
    endtask

    task automatic host_write(input logic [15:0] addr, input logic [31:0] data);
        @(posedge sysclk);
        #2;
        reg_waddr = addr;
        reg_wdata = data;
        reg_wen   = 1'b1;   // one-cycle strobe
        @(posedge sysclk);
        #2;
        reg_wen = 1'b0;
    endtask

    task automatic present_read(input logic [15:0] addr, input logic rt);
        @(posedge sysclk);
        #2;
        reg_raddr_in = addr;
        blk_rt_rd    = rt;
    endtask

    task automatic wait_for_wdog_timeout(input int limit);
        int n;
        n = 0;
        while (!wdog_timeout && n < limit) begin
            @(posedge sysclk);
            #1;                  // look after the edge settles
            n++;
        end
        if (!wdog_timeout) begin
            timeout_count++;
            $display("timeout: watchdog flag did not rise within %0d cycles", limit);
        end
    endtask

    initial begin
        seed          = 14865;
        timeout_count = 0;
        rst           = 1'b1;
        reg_raddr_in  = 16'h0000;
        blk_rt_rd     = 1'b0;
        reg_waddr     = 16'h0000;
        reg_wdata     = 32'd0;
        reg_wen       = 1'b0;
        wdog_clear    = 1'b0;
        repeat (8) @(posedge sysclk);
        #2;
        rst = 1'b0;
        idle_cycles(2);

        // ----------------------------------------
        // translation, whole block plus one past the end
        for (int i = 0; i <= block_quads; i++)
            present_read({8'h00, 8'(i)}, 1'b1);
        repeat (16) present_read(16'($random(seed)), 1'b0);   // plain reads pass through

        // hub memory write then read back
        for (int a = 1; a < 9; a++)
            host_write(16'h1000 | 16'(a), $random(seed));
        for (int a = 1; a < 9; a++)
            present_read(16'h1000 | 16'(a), 1'b0);
        foreach (probe_addr[n])
            present_read(probe_addr[n], 1'b0);

        // broadcast request for this board, then one without it
        host_write(16'h1000, $random(seed) | (32'h1 << (16 + this_board)));
        host_write(16'h1000, $random(seed) & ~(32'h1 << (16 + this_board)));
        idle_cycles(2);

        // ----------------------------------------
        // watchdog, period 5 means 40 cycles
        host_write(16'h0003, 32'd5);
        present_read(16'h0003, 1'b0);
        repeat (4) begin
            idle_cycles(16);
            host_write(16'h0010, $random(seed));   // channel 1 write keeps it alive
        end
        present_read(16'h0000, 1'b0);              // status with the flag
        wait_for_wdog_timeout(5 * wdog_tick + wdog_tick + 8);
        idle_cycles(wdog_tick + 4);                // flag stays up past its window
        @(posedge sysclk);
        #2;
        wdog_clear = 1'b1;
        @(posedge sysclk);
        #2;
        wdog_clear = 1'b0;
        idle_cycles(3);
        host_write(16'h0003, 32'd20);     // range 2
        host_write(16'h0003, 32'd300);    // range 3
        host_write(16'h0003, 32'd5000);   // range 4
        host_write(16'h0003, 32'd0);      // off
        idle_cycles(4);

        fail_total = i_board_bus_core.i_board_bus_core_properties.fail_count;
        $display("assertion failures: %0d, timeouts: %0d", fail_total, timeout_count);
        if (fail_total == 0 && timeout_count == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
rtl/board_bus_pkg.sv
rtl/read_addr_xlate.sv
rtl/board_regs.sv
rtl/hub_mem.sv
rtl/board_bus_core.sv
bench/board_bus_core_properties.sv
bench/tb_board_bus_core.sv

//--- rtl/board_bus_core.sv
// register bus core, top level
// address translation, board registers, hub memory
// and the read data select across address spaces
`timescale 1ns/1ps
`default_nettype none

module board_bus_core #(
    parameter int num_motors    = 4,
    parameter int num_encoders  = 4,
    parameter int wdog_tick     = 8,
    parameter int hub_addr_bits = 6
) (
    input  logic        sysclk,
    input  logic        rst,
    input  logic [3:0]  board_id,          // rotary switch
    input  logic [15:0] reg_raddr_in,      // host read address
    input  logic        blk_rt_rd,         // real-time block read level
    input  logic [15:0] reg_waddr,
    input  logic [31:0] reg_wdata,
    input  logic        reg_wen,           // one-cycle write strobe
    output logic [15:0] reg_raddr,         // translated, also to external regs
    input  logic [31:0] reg_rdata_ext,     // external regs, one cycle late
    output logic [31:0] reg_rdata,
    output logic [15:0] bc_sequence,
    output logic        write_trig,
    input  logic        wdog_clear,
    output logic        wdog_timeout,
    output logic        wdog_period_led,
    output logic [2:0]  wdog_period_status
);

    logic [31:0] rdata_chan0;              // from board_regs
    logic [31:0] rdata_hub;                // from hub_mem
    logic [3:0]  space_q;                  // space of previous read address
    logic        chan0_q;                  // previous address was channel 0

    read_addr_xlate #(
        .num_motors   (num_motors),
        .num_encoders (num_encoders)
    ) i_read_addr_xlate (
        .reg_raddr_in (reg_raddr_in),
        .blk_rt_rd    (blk_rt_rd),
        .reg_raddr    (reg_raddr)
    );

    board_regs #(
        .wdog_tick (wdog_tick)
    ) i_board_regs (
        .sysclk (sysclk), .rst (rst), .board_id (board_id),
        .reg_raddr (reg_raddr), .reg_waddr (reg_waddr), .reg_wdata (reg_wdata),
        .reg_wen (reg_wen), .reg_rdata_ext (reg_rdata_ext), .reg_rdata (rdata_chan0),
        .wdog_clear (wdog_clear), .wdog_timeout (wdog_timeout),
        .wdog_period_led (wdog_period_led), .wdog_period_status (wdog_period_status)
    );

    hub_mem #(
        .hub_addr_bits (hub_addr_bits)
    ) i_hub_mem (
        .sysclk (sysclk), .rst (rst), .board_id (board_id),
        .reg_raddr (reg_raddr), .reg_waddr (reg_waddr), .reg_wdata (reg_wdata),
        .reg_wen (reg_wen), .reg_rdata (rdata_hub),
        .bc_sequence (bc_sequence), .write_trig (write_trig)
    );

    // ----------------------------------------
    // read data select
    // ----------------------------------------
    // selects follow the sources, which all answer one cycle late
    always_ff @(posedge sysclk) begin
        if (rst) begin
            space_q <= board_bus_pkg::addr_main;
            chan0_q <= 1'b0;
        end else begin
            space_q <= reg_raddr[15:12];
            chan0_q <= (reg_raddr[7:4] == 4'd0);
        end
    end

    always_comb begin
        case (space_q)
            board_bus_pkg::addr_hub:  reg_rdata = rdata_hub;
            board_bus_pkg::addr_main: reg_rdata = chan0_q ? rdata_chan0 : reg_rdata_ext;
            board_bus_pkg::addr_prom: reg_rdata = reg_rdata_ext;   // no prom on this core
            default:                  reg_rdata = reg_rdata_ext;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/board_bus_pkg.sv
// shared constants for the board register bus
// address space codes, channel-0 register offsets, version word,
// real-time block layout and status word bit positions
`default_nettype none

package board_bus_pkg;

    // ----------------------------------------
    // address spaces, in reg_raddr[15:12]
    // ----------------------------------------
    localparam logic [3:0] addr_main = 4'd0;     // board and channel registers
    localparam logic [3:0] addr_hub  = 4'd1;     // hub quadlet memory
    localparam logic [3:0] addr_prom = 4'd2;     // prom space, answered externally

    // ----------------------------------------
    // channel-0 register offsets, in reg_raddr[3:0]
    // ----------------------------------------
    localparam logic [3:0] reg_status  = 4'd0;   // board id, wdog flag
    localparam logic [3:0] reg_wdog    = 4'd3;   // watchdog period
    localparam logic [3:0] reg_version = 4'd7;   // firmware version
    localparam logic [3:0] reg_ipaddr  = 4'd11;  // ip address (no ethernet here)
    localparam logic [3:0] reg_ethstat = 4'd12;  // ethernet status, always zero

    // firmware version word
    localparam logic [31:0] fw_version = 32'h4246_0008;

    // no ethernet on this board, so the ip reads as broadcast
    localparam logic [31:0] ip_addr_none = 32'hffff_ffff;

    // ----------------------------------------
    // real-time block layout
    // ----------------------------------------
    localparam int rt_main_quads  = 4;   // quadlets of channel 0 at block start
    localparam int enc_field_base = 4;   // first channel offset of encoder fields

    // status word fields
    localparam int status_id_lsb   = 24;  // board_id in 27..24
    localparam int status_wdog_bit = 23;  // wdog_timeout

endpackage

`default_nettype wire

//--- rtl/board_regs.sv
// channel-0 board registers
// watchdog period, prescaler, counter and timeout flag
// registered read mux over the channel-0 offsets
`timescale 1ns/1ps
`default_nettype none

module board_regs #(
    parameter int wdog_tick = 8          // cycles per watchdog count
) (
    input  logic        sysclk,
    input  logic        rst,
    input  logic [3:0]  board_id,
    input  logic [15:0] reg_raddr,
    input  logic [15:0] reg_waddr,
    input  logic [31:0] reg_wdata,
    input  logic        reg_wen,
    input  logic [31:0] reg_rdata_ext,      // data for offsets not kept here
    output logic [31:0] reg_rdata,          // valid one cycle after reg_raddr
    input  logic        wdog_clear,
    output logic        wdog_timeout,
    output logic        wdog_period_led,
    output logic [2:0]  wdog_period_status
);

    localparam int tick_w = (wdog_tick > 1) ? $clog2(wdog_tick) : 1;
    localparam logic [tick_w-1:0] tick_last = tick_w'(wdog_tick - 1);

    logic [15:0]       wdog_period;
    logic [15:0]       wdog_count;
    logic [tick_w-1:0] wdog_presc;
    logic              wen_main;          // any main-space write
    logic              wen_period;        // write of the period register
    logic              tick;
    logic [31:0]       status_word;
    logic [31:0]       rdata_q;           // claimed register value
    logic              ext_q;             // previous offset is answered externally

    assign wen_main   = reg_wen && (reg_waddr[15:12] == board_bus_pkg::addr_main);
    assign wen_period = wen_main && (reg_waddr[7:4] == 4'd0) &&
                        (reg_waddr[3:0] == board_bus_pkg::reg_wdog);
    assign tick       = (wdog_presc == tick_last);

    // ----------------------------------------
    // watchdog
    // ----------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            wdog_period  <= 16'd0;
            wdog_count   <= 16'd0;
            wdog_presc   <= '0;
            wdog_timeout <= 1'b0;
        end else begin
            if (wen_main) begin
                wdog_count <= 16'd0;                  // host is alive
                wdog_presc <= '0;
            end else if (tick) begin
                wdog_presc <= '0;
                if (wdog_count != wdog_period)
                    wdog_count <= wdog_count + 16'd1; // saturate at the period
            end else begin
                wdog_presc <= wdog_presc + 1'b1;
            end
            if (wen_period)
                wdog_period <= reg_wdata[15:0];
            // set on the tick that reaches the period, then held
            if (wdog_clear || wen_period)
                wdog_timeout <= 1'b0;
            else if (!wen_main && tick && (wdog_period != 16'd0) &&
                     (wdog_count + 16'd1 == wdog_period))
                wdog_timeout <= 1'b1;
        end
    end

    // led range code for the period
    always_comb begin
        if (wdog_period == 16'd0)       wdog_period_status = 3'd0;   // off
        else if (wdog_period <= 16'd15)   wdog_period_status = 3'd1;
        else if (wdog_period <= 16'd255)  wdog_period_status = 3'd2;
        else if (wdog_period <= 16'd4095) wdog_period_status = 3'd3;
        else                             wdog_period_status = 3'd4;
    end
    assign wdog_period_led = (wdog_period != 16'd0);

    // ----------------------------------------
    // read mux
    // ----------------------------------------
    always_comb begin
        status_word = 32'd0;
        status_word[board_bus_pkg::status_id_lsb +: 4] = board_id;
        status_word[board_bus_pkg::status_wdog_bit]    = wdog_timeout;
    end

    // space and channel are qualified at the top level
    always_ff @(posedge sysclk) begin
        ext_q <= 1'b0;
        case (reg_raddr[3:0])
            board_bus_pkg::reg_status:  rdata_q <= status_word;
            board_bus_pkg::reg_wdog:    rdata_q <= {16'd0, wdog_period};
            board_bus_pkg::reg_version: rdata_q <= board_bus_pkg::fw_version;
            board_bus_pkg::reg_ipaddr:  rdata_q <= board_bus_pkg::ip_addr_none;
            board_bus_pkg::reg_ethstat: rdata_q <= 32'd0;
            default:                    ext_q   <= 1'b1;
        endcase
    end

    // external data already arrives one cycle after the address
    assign reg_rdata = ext_q ? reg_rdata_ext : rdata_q;

endmodule

`default_nettype wire

//--- rtl/hub_mem.sv
// hub quadlet memory with synchronous read
// broadcast sequence number and broadcast write trigger
`timescale 1ns/1ps
`default_nettype none

module hub_mem #(
    parameter int hub_addr_bits = 6       // memory depth is 2**hub_addr_bits
) (
    input  logic        sysclk,
    input  logic        rst,
    input  logic [3:0]  board_id,
    input  logic [15:0] reg_raddr,
    input  logic [15:0] reg_waddr,
    input  logic [31:0] reg_wdata,
    input  logic        reg_wen,
    output logic [31:0] reg_rdata,         // one cycle after reg_raddr
    output logic [15:0] bc_sequence,       // last broadcast sequence number
    output logic        write_trig         // this board should broadcast
);

    localparam int depth = 2 ** hub_addr_bits;

    logic [31:0] mem [depth];              // hub quadlets
    logic        wen_hub;                  // write into hub space
    logic        wen_seq;                  // write to offset 0

    assign wen_hub = reg_wen && (reg_waddr[15:12] == board_bus_pkg::addr_hub);
    assign wen_seq = wen_hub && (reg_waddr[hub_addr_bits-1:0] == '0);

    // ----------------------------------------
    // memory
    // ----------------------------------------
    always_ff @(posedge sysclk) begin
        if (wen_hub)
            mem[reg_waddr[hub_addr_bits-1:0]] <= reg_wdata;
        reg_rdata <= mem[reg_raddr[hub_addr_bits-1:0]];   // sync read
    end

    // ----------------------------------------
    // sequence and trigger
    // ----------------------------------------
    // wdata[31:16] is a per-board request mask
    always_ff @(posedge sysclk) begin
        if (rst) begin
            bc_sequence <= 16'd0;
            write_trig  <= 1'b0;
        end else begin
            write_trig <= 1'b0;                            // single-cycle pulse
            if (wen_seq) begin
                bc_sequence <= reg_wdata[15:0];
                write_trig  <= reg_wdata[5'd16 + {1'b0, board_id}];
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/read_addr_xlate.sv
// real-time block read address translation
// maps a quadlet index within the block to a main-space register address
`timescale 1ns/1ps
`default_nettype none

module read_addr_xlate #(
    parameter int num_motors   = 4,
    parameter int num_encoders = 4
) (
    input  logic [15:0] reg_raddr_in,   // host read address or quadlet index
    input  logic        blk_rt_rd,      // real-time block read in progress
    output logic [15:0] reg_raddr       // translated register address
);

    // block segment sizes
    localparam int motor_quads = 2 * num_motors;     // two quadlets per motor
    localparam int enc_quads   = 5 * num_encoders;   // five fields per encoder

    logic [7:0] quad_idx;    // i, index within block
    logic [7:0] mot_idx;     // j = i - main quads
    logic [7:0] enc_idx;     // k = j - motor quads
    logic [3:0] chan;
    logic [3:0] offs;
    logic       in_range;    // index falls inside the block

    always_comb begin
        quad_idx = reg_raddr_in[7:0];
        mot_idx  = quad_idx - 8'(board_bus_pkg::rt_main_quads);
        enc_idx  = mot_idx - 8'(motor_quads);
        chan     = 4'd0;
        offs     = 4'd0;
        in_range = 1'b1;
        // earlier tests shadow the wrapped differences of later ones
        if (quad_idx < 8'(board_bus_pkg::rt_main_quads)) begin
            offs = quad_idx[3:0];                        // channel 0 registers
        end else if (mot_idx < 8'(motor_quads)) begin
            chan = 4'(mot_idx >> 1) + 4'd1;              // motor pairs, one per channel
            offs = {3'b000, mot_idx[0]};
        end else if (enc_idx < 8'(enc_quads)) begin
            // fields are grouped, all channels of one field together
            chan = 4'(enc_idx % num_encoders) + 4'd1;
            offs = 4'(board_bus_pkg::enc_field_base + enc_idx / num_encoders);
        end else begin
            in_range = 1'b0;                             // past end of block
        end
    end

    // plain reads pass straight through
    assign reg_raddr = !blk_rt_rd ? reg_raddr_in :
                       in_range   ? {board_bus_pkg::addr_main, 4'h0, chan, offs} :
                                    16'h0000;

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the board_bus_core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_board_bus_core -f filelist.f \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_board_bus_core +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -qx "No errors" sim.log && echo "simulation passed" || {
    echo "simulation failed"
    exit 1
}
exit 0
